// File: decode_pkg.sv
package decode_pkg;

  localparam int XLEN = 32;
  localparam int PC_W = 16;

  // Major opcodes of RV32I
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;

  // addi x0, x0, 0
  localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

  ///////////////////////////////////////////////////////////////////////
  // Instruction layouts
  ///////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One word, six readings
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

  ///////////////////////////////////////////////////////////////////////
  // Control and pipeline bundles
  ///////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       alu_src;
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    logic       branch;
    logic       jal;
    logic       jalr;
    logic       lui;
    logic       auipc;
    logic [2:0] mem_size;
  } ctrl_t;

  // Destinations and results of the later stages
  typedef struct packed {
    logic [4:0]      ex_mem_rd;
    logic            ex_mem_reg_write;
    logic            ex_mem_mem_read;
    logic [XLEN-1:0] ex_mem_res;
    logic [4:0]      mem_wb_rd;
    logic            mem_wb_reg_write;
    logic [XLEN-1:0] wb_res;
  } fwd_src_t;

  typedef struct packed {
    ctrl_t           ctrl;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm;
    logic [PC_W-1:0] pc;
    logic [2:0]      funct3;
  } id_ex_t;

endpackage

// File: if_id_reg.sv
`timescale 1ns/100ps

module if_id_reg #(
  parameter int PC_W = decode_pkg::PC_W
) (
  input  logic               bus,
  input  logic               reset,
  input  logic               stall,
  input  logic               hold,
  input  logic               flush,
  input  logic [31:0]        ins,
  input  logic [PC_W-1:0]    ins_pc,
  input  logic               ins_valid,
  output decode_pkg::instr_u ifid_instr,
  output logic [PC_W-1:0]    ifid_pc,
  output logic               ifid_valid
);

  import decode_pkg::*;

  always_ff @(posedge bus) begin
    if (reset) begin
      ifid_instr <= NOP_INSTR;
      ifid_pc    <= '0;
      ifid_valid <= 1'b0;
    end else if (!stall && !hold) begin
      // Taken branch kills the instruction behind it
      if (flush || !ins_valid) begin
        ifid_instr <= NOP_INSTR;
        ifid_valid <= 1'b0;
      end else begin
        ifid_instr <= ins;
        ifid_valid <= 1'b1;
      end
      // pc follows fetch even for a slot turned into a NOP
      ifid_pc <= ins_pc;
    end
  end

endmodule

// File: control_decode.sv
`timescale 1ns/100ps

module control_decode (
  input  decode_pkg::instr_u instr,
  input  logic               valid,
  output decode_pkg::ctrl_t  ctrl,
  output logic               uses_rs1,
  output logic               uses_rs2
);

  import decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;

  assign opcode = instr.r_fmt.opcode;
  assign funct3 = instr.r_fmt.funct3;
  // funct7 bit 5 selects sub and sra
  assign alt    = instr.r_fmt.funct7[5];

  function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic f7_alt,
                                             input logic is_reg);
    case (f3)
      3'b000:  return (is_reg && f7_alt) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return f7_alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    ctrl     = '0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    if (valid) begin
      case (opcode)
        OP_LUI: begin
          ctrl.lui       = 1'b1;
          ctrl.alu_src   = 1'b1;
          ctrl.alu_op    = ALU_PASS_B;
          ctrl.reg_write = 1'b1;
        end
        OP_AUIPC: begin
          ctrl.auipc     = 1'b1;
          ctrl.alu_src   = 1'b1;
          ctrl.reg_write = 1'b1;
        end
        OP_JAL: begin
          ctrl.jal       = 1'b1;
          ctrl.reg_write = 1'b1;
        end
        OP_JALR: begin
          ctrl.jalr      = 1'b1;
          ctrl.alu_src   = 1'b1;
          ctrl.reg_write = 1'b1;
          uses_rs1       = 1'b1;
        end
        OP_BRANCH: begin
          ctrl.branch = 1'b1;
          ctrl.alu_op = ALU_SUB;
          uses_rs1    = 1'b1;
          uses_rs2    = 1'b1;
        end
        OP_LOAD: begin
          ctrl.mem_read  = 1'b1;
          ctrl.alu_src   = 1'b1;
          ctrl.reg_write = 1'b1;
          ctrl.mem_size  = funct3;
          uses_rs1       = 1'b1;
        end
        OP_STORE: begin
          ctrl.mem_write = 1'b1;
          ctrl.alu_src   = 1'b1;
          ctrl.mem_size  = funct3;
          uses_rs1       = 1'b1;
          uses_rs2       = 1'b1;
        end
        OP_IMM: begin
          ctrl.alu_op    = alu_from_funct(funct3, alt, 1'b0);
          ctrl.alu_src   = 1'b1;
          ctrl.reg_write = 1'b1;
          uses_rs1       = 1'b1;
        end
        OP_REG: begin
          ctrl.alu_op    = alu_from_funct(funct3, alt, 1'b1);
          ctrl.reg_write = 1'b1;
          uses_rs1       = 1'b1;
          uses_rs2       = 1'b1;
        end
        default: ctrl = '0;
      endcase
    end
  end

endmodule

// File: imm_gen.sv
`timescale 1ns/100ps

module imm_gen #(
  parameter int XLEN = decode_pkg::XLEN
) (
  input  decode_pkg::instr_u instr,
  output logic [XLEN-1:0]    imm
);

  import decode_pkg::*;

  logic [31:0] imm32;

  always_comb begin
    case (instr.r_fmt.opcode)
      OP_LOAD, OP_IMM, OP_JALR:
        imm32 = {{20{instr.i_fmt.imm11_0[11]}}, instr.i_fmt.imm11_0};
      OP_STORE:
        imm32 = {{20{instr.s_fmt.imm11_5[6]}}, instr.s_fmt.imm11_5, instr.s_fmt.imm4_0};
      OP_BRANCH:
        imm32 = {{20{instr.b_fmt.imm12}}, instr.b_fmt.imm11, instr.b_fmt.imm10_5,
                 instr.b_fmt.imm4_1, 1'b0};
      OP_LUI, OP_AUIPC:
        imm32 = {instr.u_fmt.imm31_12, 12'h000};
      OP_JAL:
        imm32 = {{12{instr.j_fmt.imm20}}, instr.j_fmt.imm19_12, instr.j_fmt.imm11,
                 instr.j_fmt.imm10_1, 1'b0};
      // R format and unknown opcodes carry no immediate
      default: imm32 = '0;
    endcase
  end

  assign imm = XLEN'(signed'(imm32));

endmodule

// File: hazard_forward.sv
`timescale 1ns/100ps

module hazard_forward #(
  parameter int XLEN = decode_pkg::XLEN
) (
  input  decode_pkg::instr_u   instr,
  input  decode_pkg::ctrl_t    ctrl,
  input  logic                 valid,
  input  logic                 uses_rs1,
  input  logic                 uses_rs2,
  input  decode_pkg::id_ex_t   id_ex,
  input  decode_pkg::fwd_src_t fwd,
  input  logic [XLEN-1:0]      rs1_data,
  input  logic [XLEN-1:0]      rs2_data,
  output logic                 hz,
  output logic [XLEN-1:0]      op_a,
  output logic [XLEN-1:0]      op_b
);

  import decode_pkg::*;

  logic [4:0] rs1;
  logic [4:0] rs2;
  logic       live1;
  logic       live2;
  logic       id_match;
  logic       ex_match;
  logic       cmp_in_id;

  assign rs1   = instr.r_fmt.rs1;
  assign rs2   = instr.r_fmt.rs2;
  // x0 never causes a dependency
  assign live1 = uses_rs1 && (rs1 != 5'd0);
  assign live2 = uses_rs2 && (rs2 != 5'd0);

  assign id_match = (live1 && rs1 == id_ex.rd) || (live2 && rs2 == id_ex.rd);
  assign ex_match = (live1 && rs1 == fwd.ex_mem_rd) || (live2 && rs2 == fwd.ex_mem_rd);

  // Branches and jalr need their operands here, not in execute
  assign cmp_in_id = ctrl.branch || ctrl.jalr;

  assign hz = valid &&
              ((id_match && (id_ex.ctrl.mem_read || (cmp_in_id && id_ex.ctrl.reg_write))) ||
               (ex_match && cmp_in_id && fwd.ex_mem_mem_read));

  // EX/MEM first, then write-back, then register file
  function automatic logic [XLEN-1:0] fwd_pick(input logic [4:0] rs, input fwd_src_t src,
                                               input logic [XLEN-1:0] rf);
    if (src.ex_mem_reg_write && src.ex_mem_rd != 5'd0 && src.ex_mem_rd == rs)
      return src.ex_mem_res;
    if (src.mem_wb_reg_write && src.mem_wb_rd != 5'd0 && src.mem_wb_rd == rs)
      return src.wb_res;
    return rf;
  endfunction

  assign op_a = fwd_pick(rs1, fwd, rs1_data);
  assign op_b = fwd_pick(rs2, fwd, rs2_data);

endmodule

// File: branch_resolve.sv
`timescale 1ns/100ps

module branch_resolve #(
  parameter int XLEN = decode_pkg::XLEN,
  parameter int PC_W = decode_pkg::PC_W
) (
  input  decode_pkg::ctrl_t ctrl,
  input  logic [2:0]        funct3,
  input  logic [XLEN-1:0]   op_a,
  input  logic [XLEN-1:0]   op_b,
  input  logic [XLEN-1:0]   imm,
  input  logic [PC_W-1:0]   pc,
  input  logic              hz,
  output logic              branch_taken,
  output logic [PC_W-1:0]   branch_target
);

  import decode_pkg::*;

  logic            cond;
  logic [XLEN-1:0] base;
  logic [XLEN-1:0] sum;

  always_comb begin
    case (funct3)
      3'b000:  cond = (op_a == op_b);
      3'b001:  cond = (op_a != op_b);
      3'b100:  cond = ($signed(op_a) < $signed(op_b));
      3'b101:  cond = ($signed(op_a) >= $signed(op_b));
      3'b110:  cond = (op_a < op_b);
      3'b111:  cond = (op_a >= op_b);
      default: cond = 1'b0;
    endcase
  end

  // Operands are not final while a hazard is pending
  assign branch_taken = !hz && (ctrl.jal || ctrl.jalr || (ctrl.branch && cond));

  assign base = ctrl.jalr ? op_a : XLEN'(pc);
  assign sum  = base + imm;

  // jalr clears bit 0 of its target
  assign branch_target = {sum[PC_W-1:1], sum[0] & ~ctrl.jalr};

endmodule

// File: id_ex_reg.sv
`timescale 1ns/100ps

module id_ex_reg (
  input  logic               bus,
  input  logic               reset,
  input  logic               stall,
  input  logic               bubble,
  input  decode_pkg::id_ex_t next,
  output decode_pkg::id_ex_t id_ex
);

  import decode_pkg::*;

  id_ex_t bubble_entry;

  // Empty slot that still carries the pc of the held instruction
  always_comb begin
    bubble_entry    = '0;
    bubble_entry.pc = next.pc;
  end

  always_ff @(posedge bus) begin
    if (reset) begin
      id_ex <= '0;
    end else if (!stall) begin
      if (bubble) begin
        id_ex <= bubble_entry;
      end else begin
        id_ex <= next;
      end
    end
  end

endmodule

// File: decode_stage.sv
`timescale 1ns/100ps

module decode_stage #(
  parameter int XLEN = decode_pkg::XLEN,
  parameter int PC_W = decode_pkg::PC_W
) (
  input  logic                 bus,
  input  logic                 reset,
  input  logic                 stall,
  input  logic [31:0]          ins,
  input  logic [PC_W-1:0]      ins_pc,
  input  logic                 ins_valid,
  output logic [4:0]           rf_rs1,
  output logic [4:0]           rf_rs2,
  input  logic [XLEN-1:0]      rs1_data,
  input  logic [XLEN-1:0]      rs2_data,
  input  decode_pkg::fwd_src_t fwd,
  output decode_pkg::id_ex_t   id_ex,
  output logic                 hz,
  output logic                 branch_taken,
  output logic [PC_W-1:0]      branch_target
);

  import decode_pkg::*;

  instr_u          ifid_instr;
  logic [PC_W-1:0] ifid_pc;
  logic            ifid_valid;
  ctrl_t           ctrl;
  logic            uses_rs1;
  logic            uses_rs2;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  id_ex_t          next;

  ////////////////////////////////////////////////////////////////////////
  // IF/ID
  ////////////////////////////////////////////////////////////////////////

  if_id_reg #(.PC_W(PC_W)) u_if_id (
    .bus        (bus),
    .reset      (reset),
    .stall      (stall),
    .hold       (hz),
    .flush      (branch_taken),
    .ins        (ins),
    .ins_pc     (ins_pc),
    .ins_valid  (ins_valid),
    .ifid_instr (ifid_instr),
    .ifid_pc    (ifid_pc),
    .ifid_valid (ifid_valid)
  );

  assign rf_rs1 = ifid_instr.r_fmt.rs1;
  assign rf_rs2 = ifid_instr.r_fmt.rs2;

  ////////////////////////////////////////////////////////////////////////
  // Decode, hazards and branches
  ////////////////////////////////////////////////////////////////////////

  control_decode u_control (
    .instr    (ifid_instr),
    .valid    (ifid_valid),
    .ctrl     (ctrl),
    .uses_rs1 (uses_rs1),
    .uses_rs2 (uses_rs2)
  );

  imm_gen #(.XLEN(XLEN)) u_imm (
    .instr (ifid_instr),
    .imm   (imm)
  );

  hazard_forward #(.XLEN(XLEN)) u_hazard (
    .instr    (ifid_instr),
    .ctrl     (ctrl),
    .valid    (ifid_valid),
    .uses_rs1 (uses_rs1),
    .uses_rs2 (uses_rs2),
    .id_ex    (id_ex),
    .fwd      (fwd),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .hz       (hz),
    .op_a     (op_a),
    .op_b     (op_b)
  );

  branch_resolve #(.XLEN(XLEN), .PC_W(PC_W)) u_branch (
    .ctrl          (ctrl),
    .funct3        (ifid_instr.r_fmt.funct3),
    .op_a          (op_a),
    .op_b          (op_b),
    .imm           (imm),
    .pc            (ifid_pc),
    .hz            (hz),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  ////////////////////////////////////////////////////////////////////////
  // ID/EX
  ////////////////////////////////////////////////////////////////////////

  // Unused register fields go out as x0 so later stages see no false match
  always_comb begin
    next          = '0;
    next.ctrl     = ctrl;
    next.rs1      = uses_rs1 ? ifid_instr.r_fmt.rs1 : 5'd0;
    next.rs2      = uses_rs2 ? ifid_instr.r_fmt.rs2 : 5'd0;
    next.rd       = ctrl.reg_write ? ifid_instr.r_fmt.rd : 5'd0;
    next.rs1_data = rs1_data;
    next.rs2_data = rs2_data;
    next.imm      = imm;
    next.pc       = ifid_pc;
    next.funct3   = ifid_instr.r_fmt.funct3;
  end

  id_ex_reg u_id_ex (
    .bus    (bus),
    .reset  (reset),
    .stall  (stall),
    .bubble (hz),
    .next   (next),
    .id_ex  (id_ex)
  );

endmodule

// File: decode_stage_asserts.sv
`timescale 1ns/100ps

module decode_stage_asserts (
  input logic               bus,
  input logic               reset,
  input logic               stall,
  input logic               bubble,
  input decode_pkg::id_ex_t id_ex
);

  import decode_pkg::*;

  // Bubble carries no control
  assert property (@(posedge bus) disable iff (reset)
                   (!stall && bubble) |=> (id_ex.ctrl == '0))
    else $error("bubble left control bits set");

  assert property (@(posedge bus) disable iff (reset) stall |=> $stable(id_ex))
    else $error("id_ex changed under stall");

  assert property (@(posedge bus) reset |=> (id_ex == '0))
    else $error("id_ex not cleared by reset");

  assert property (@(posedge bus) !(id_ex.ctrl.mem_read && id_ex.ctrl.mem_write))
    else $error("load and store flags both set");

endmodule

// File: tb_decode_stage.sv
`timescale 1ns/100ps

module tb_decode_stage;

  import decode_pkg::*;

  localparam int TB_XLEN = decode_pkg::XLEN;
  localparam int TB_PC_W = decode_pkg::PC_W;

  logic                bus;
  logic                reset;
  logic                stall;
  logic [31:0]         ins;
  logic [TB_PC_W-1:0]  ins_pc;
  logic                ins_valid;
  logic [4:0]          rf_rs1;
  logic [4:0]          rf_rs2;
  logic [TB_XLEN-1:0]  rs1_data;
  logic [TB_XLEN-1:0]  rs2_data;
  fwd_src_t            fwd;
  id_ex_t              id_ex;
  logic                hz;
  logic                branch_taken;
  logic [TB_PC_W-1:0]  branch_target;

  logic [31:0]         regs [32];
  logic [31:0]         rng;
  id_ex_t              exp_q [$];
  logic [TB_PC_W-1:0]  pc_ctr;
  logic [TB_PC_W-1:0]  last_pc;
  int                  val_errs;
  int                  other_errs;

  decode_stage #(.XLEN(TB_XLEN), .PC_W(TB_PC_W)) decode_stage_inst (
    .bus           (bus),
    .reset         (reset),
    .stall         (stall),
    .ins           (ins),
    .ins_pc        (ins_pc),
    .ins_valid     (ins_valid),
    .rf_rs1        (rf_rs1),
    .rf_rs2        (rf_rs2),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .fwd           (fwd),
    .id_ex         (id_ex),
    .hz            (hz),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  bind id_ex_reg decode_stage_asserts asserts_inst (
    .bus    (bus),
    .reset  (reset),
    .stall  (stall),
    .bubble (bubble),
    .id_ex  (id_ex)
  );

  // Register file model answers in the same cycle
  assign rs1_data = regs[rf_rs1];
  assign rs2_data = regs[rf_rs2];

  initial begin
    bus = 1'b0;
    forever #2 bus = ~bus;
  end

  function logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic check(input string name, input logic [255:0] got, input logic [255:0] exp);
    if (got !== exp) begin
      val_errs++;
      $display("ERR %s got %0h expected %0h", name, got, exp);
    end
  endtask

  ///////////////////////////////////////////////////////////////////////
  // Reference model
  ///////////////////////////////////////////////////////////////////////

  function automatic alu_op_e alu_expect(input logic [2:0] f3, input logic alt,
                                         input logic is_reg);
    case (f3)
      3'd0:    return (is_reg && alt) ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return alt ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic id_ex_t ref_decode(input logic [31:0] w, input logic [TB_PC_W-1:0] pc,
                                        input logic [31:0] d1, input logic [31:0] d2);
    id_ex_t e;
    logic   u1;
    logic   u2;
    e  = '0;
    u1 = 1'b0;
    u2 = 1'b0;
    case (w[6:0])
      OP_LUI: begin
        e.ctrl.lui = 1'b1;
        e.ctrl.alu_src = 1'b1;
        e.ctrl.alu_op = ALU_PASS_B;
        e.ctrl.reg_write = 1'b1;
        e.imm = {w[31:12], 12'h000};
      end
      OP_AUIPC: begin
        e.ctrl.auipc = 1'b1;
        e.ctrl.alu_src = 1'b1;
        e.ctrl.reg_write = 1'b1;
        e.imm = {w[31:12], 12'h000};
      end
      OP_JAL: begin
        e.ctrl.jal = 1'b1;
        e.ctrl.reg_write = 1'b1;
        e.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      OP_JALR: begin
        e.ctrl.jalr = 1'b1;
        e.ctrl.alu_src = 1'b1;
        e.ctrl.reg_write = 1'b1;
        u1 = 1'b1;
        e.imm = {{20{w[31]}}, w[31:20]};
      end
      OP_BRANCH: begin
        e.ctrl.branch = 1'b1;
        e.ctrl.alu_op = ALU_SUB;
        u1 = 1'b1;
        u2 = 1'b1;
        e.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      end
      OP_LOAD: begin
        e.ctrl.mem_read = 1'b1;
        e.ctrl.alu_src = 1'b1;
        e.ctrl.reg_write = 1'b1;
        e.ctrl.mem_size = w[14:12];
        u1 = 1'b1;
        e.imm = {{20{w[31]}}, w[31:20]};
      end
      OP_STORE: begin
        e.ctrl.mem_write = 1'b1;
        e.ctrl.alu_src = 1'b1;
        e.ctrl.mem_size = w[14:12];
        u1 = 1'b1;
        u2 = 1'b1;
        e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
      end
      OP_IMM: begin
        e.ctrl.alu_op = alu_expect(w[14:12], w[30], 1'b0);
        e.ctrl.alu_src = 1'b1;
        e.ctrl.reg_write = 1'b1;
        u1 = 1'b1;
        e.imm = {{20{w[31]}}, w[31:20]};
      end
      OP_REG: begin
        e.ctrl.alu_op = alu_expect(w[14:12], w[30], 1'b1);
        e.ctrl.reg_write = 1'b1;
        u1 = 1'b1;
        u2 = 1'b1;
      end
      default: e = '0;
    endcase
    e.rs1      = u1 ? w[19:15] : 5'd0;
    e.rs2      = u2 ? w[24:20] : 5'd0;
    e.rd       = e.ctrl.reg_write ? w[11:7] : 5'd0;
    e.rs1_data = d1;
    e.rs2_data = d2;
    e.pc       = pc;
    e.funct3   = w[14:12];
    return e;
  endfunction

  // Branch operand by forwarding priority
  function automatic logic [31:0] operand_expect(input logic [4:0] rs, input fwd_src_t f);
    if (rs != 0 && f.ex_mem_reg_write && f.ex_mem_rd == rs)
      return f.ex_mem_res;
    if (rs != 0 && f.mem_wb_reg_write && f.mem_wb_rd == rs)
      return f.wb_res;
    return regs[rs];
  endfunction

  function automatic logic taken_expect(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      3'd7:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  ///////////////////////////////////////////////////////////////////////
  // Compare process
  ///////////////////////////////////////////////////////////////////////

  // A new real entry on id_ex is matched against the oldest expected one
  always @(negedge bus) begin
    id_ex_t e;
    if (!reset && id_ex.ctrl != '0 && id_ex.pc != last_pc) begin
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("Unexpected instruction on id_ex at pc %h", id_ex.pc);
      end else begin
        e = exp_q.pop_front();
        check("id_ex.pc", id_ex.pc, e.pc);
        check("id_ex.ctrl", id_ex.ctrl, e.ctrl);
        check("id_ex.rs1", id_ex.rs1, e.rs1);
        check("id_ex.rs2", id_ex.rs2, e.rs2);
        check("id_ex.rd", id_ex.rd, e.rd);
        check("id_ex.imm", id_ex.imm, e.imm);
        check("id_ex.rs1_data", id_ex.rs1_data, e.rs1_data);
        check("id_ex.rs2_data", id_ex.rs2_data, e.rs2_data);
        check("id_ex.funct3", id_ex.funct3, e.funct3);
      end
      last_pc = id_ex.pc;
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ///////////////////////////////////////////////////////////////////////

  task automatic issue(input logic [31:0] w, input bit expect_it);
    @(negedge bus);
    stall     = 1'b0;
    ins       = w;
    ins_pc    = pc_ctr;
    ins_valid = 1'b1;
    if (expect_it)
      exp_q.push_back(ref_decode(w, pc_ctr, regs[w[19:15]], regs[w[24:20]]));
    pc_ctr = pc_ctr + 16'd4;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge bus);
      stall     = 1'b0;
      ins_valid = 1'b0;
    end
  endtask

  task automatic stall_for(input int n);
    id_ex_t snap;
    for (int i = 0; i <= n; i++) begin
      @(negedge bus);
      if (i == 0)
        snap = id_ex;
      else
        check("id_ex during stall", id_ex, snap);
      stall = (i < n);
      // The issued instruction already sits in IF/ID
      ins_valid = 1'b0;
    end
  endtask

  // Independent mix with sources in x1..x15 and destinations in x16..x31
  function automatic logic [31:0] random_indep();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  s1;
    logic [4:0]  s2;
    logic [2:0]  f3;
    logic [11:0] i12;
    r   = xorshift();
    rd  = 5'd16 + 5'(r[3:0]);
    s1  = 5'd1 + 5'(r[7:4] % 15);
    s2  = 5'd1 + 5'(r[11:8] % 15);
    f3  = r[14:12];
    i12 = xorshift() & 32'hfff;
    if (f3 == 3'd1)
      i12 = {7'h00, i12[4:0]};
    else if (f3 == 3'd5)
      i12 = {r[15] ? 7'h20 : 7'h00, i12[4:0]};
    case (r[31:16] % 6)
      0: return {(r[15] && (f3 == 0 || f3 == 5)) ? 7'h20 : 7'h00, s2, s1, f3, rd, OP_REG};
      1: return {i12, s1, f3, rd, OP_IMM};
      2: return {i12, s1, f3, rd, OP_LOAD};
      3: return {i12[11:5], s2, s1, f3, i12[4:0], OP_STORE};
      4: return {r[31:12], rd, OP_LUI};
      default: return {r[31:12], rd, OP_AUIPC};
    endcase
  endfunction

  task automatic check_redirect(input logic [TB_PC_W-1:0] exp_target, input logic exp_taken);
    @(negedge bus);
    check("branch_taken", branch_taken, exp_taken);
    if (exp_taken)
      check("branch_target", branch_target, exp_target);
  endtask

  ///////////////////////////////////////////////////////////////////////
  // Main sequence
  ///////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] w;
    logic [31:0] r;
    logic [31:0] va;
    logic [31:0] vb;
    logic [31:0] sum;
    logic [4:0]  s1;
    logic [4:0]  s2;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [12:0] bimm;
    logic [20:0] jimm;
    logic [TB_PC_W-1:0] bpc;
    logic        tk;
    int          wait_cnt;

    rng        = 32'd91861;
    val_errs   = 0;
    other_errs = 0;
    pc_ctr     = 16'h0100;
    last_pc    = '1;
    reset      = 1'b1;
    stall      = 1'b0;
    ins        = NOP_INSTR;
    ins_pc     = '0;
    ins_valid  = 1'b0;
    fwd        = '0;
    regs[0]    = '0;
    for (int i = 1; i < 32; i++)
      regs[i] = xorshift();

    repeat (3) @(posedge bus);
    @(negedge bus);
    check("id_ex", id_ex, '0);
    check("hz", hz, 1'b0);
    check("branch_taken", branch_taken, 1'b0);
    reset = 1'b0;

    // Back-to-back independent instructions
    for (int i = 0; i < 40; i++)
      issue(random_indep(), 1'b1);
    idle(3);

    // Load followed by a user of its result
    for (int i = 0; i < 4; i++) begin
      r  = xorshift();
      rd = 5'd16 + 5'(r[3:0]);
      s1 = 5'd1 + 5'(r[7:4] % 15);
      issue({r[31:20], s1, 3'd2, rd, OP_LOAD}, 1'b1);
      if (r[8])
        issue({7'h00, s1, rd, 3'd0, 5'd20, OP_REG}, 1'b1);
      else
        issue({7'h00, rd, s1, 3'd0, 5'd20, OP_REG}, 1'b1);
      @(negedge bus);
      check("hz", hz, 1'b1);
      ins_valid = 1'b0;
      @(negedge bus);
      check("hz", hz, 1'b0);
      check("id_ex.ctrl bubble", id_ex.ctrl, '0);
      idle(3);
    end

    // Branches on forwarded operands
    for (int i = 0; i < 24; i++) begin
      idle(2);
      r  = xorshift();
      s1 = 5'd1 + 5'(r[3:0] % 15);
      s2 = (s1 == 5'd15) ? 5'd1 : s1 + 5'd1;
      f3 = r[6:4];
      if (f3 == 3'd2 || f3 == 3'd3)
        f3 = 3'd0;
      va = xorshift();
      vb = r[7] ? va : xorshift();
      fwd = '0;
      fwd.ex_mem_reg_write = 1'b1;
      fwd.mem_wb_reg_write = 1'b1;
      case (i % 3)
        0: begin
          fwd.ex_mem_rd = s1;
          fwd.ex_mem_res = va;
          fwd.mem_wb_rd = s2;
          fwd.wb_res = vb;
        end
        1: begin
          fwd.ex_mem_rd = s2;
          fwd.ex_mem_res = vb;
          fwd.mem_wb_rd = s1;
          fwd.wb_res = va;
        end
        default: begin
          fwd.ex_mem_rd = s1;
          fwd.ex_mem_res = r[7] ? regs[s2] : va;
          fwd.mem_wb_rd = s1;
          fwd.wb_res = ~va;
        end
      endcase
      bimm = {xorshift() & 32'h1ffe};
      w    = {bimm[12], bimm[10:5], s2, s1, f3, bimm[4:1], bimm[11], OP_BRANCH};
      bpc  = pc_ctr;
      tk   = taken_expect(f3, operand_expect(s1, fwd), operand_expect(s2, fwd));
      issue(w, 1'b1);
      check_redirect(bpc + TB_PC_W'({{19{bimm[12]}}, bimm}), tk);
      ins       = random_indep();
      ins_pc    = pc_ctr;
      ins_valid = 1'b1;
      if (!tk)
        exp_q.push_back(ref_decode(ins, pc_ctr, regs[ins[19:15]], regs[ins[24:20]]));
      pc_ctr = pc_ctr + 16'd4;
      idle(2);
      fwd = '0;
    end

    // jal and jalr
    for (int i = 0; i < 12; i++) begin
      idle(2);
      r = xorshift();
      if (r[0]) begin
        jimm = r[21:1] & 21'h1ffffe;
        bpc  = pc_ctr;
        issue({jimm[20], jimm[10:1], jimm[11], jimm[19:12], 5'd17, OP_JAL}, 1'b1);
        check_redirect(bpc + TB_PC_W'({{11{jimm[20]}}, jimm}), 1'b1);
      end else begin
        s1  = 5'd1 + 5'(r[4:1] % 15);
        sum = regs[s1] + {{20{r[31]}}, r[31:20]};
        issue({r[31:20], s1, 3'd0, 5'd18, OP_JALR}, 1'b1);
        check_redirect(TB_PC_W'(sum & 32'hffff_fffe), 1'b1);
      end
      ins       = random_indep();
      ins_pc    = pc_ctr;
      ins_valid = 1'b1;
      pc_ctr    = pc_ctr + 16'd4;
      idle(2);
    end

    // Random stall spans between instructions
    for (int i = 0; i < 24; i++) begin
      issue(random_indep(), 1'b1);
      stall_for(int'(xorshift() % 4));
    end
    idle(2);

    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < 50) begin
      @(negedge bus);
      wait_cnt++;
    end
    if (exp_q.size() != 0) begin
      other_errs++;
      $display("Timeout with %0d instructions never seen on id_ex", exp_q.size());
    end

    $display("Errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: files.f
decode_pkg.sv
if_id_reg.sv
control_decode.sv
imm_gen.sv
hazard_forward.sv
branch_resolve.sv
id_ex_reg.sv
decode_stage.sv
decode_stage_asserts.sv
tb_decode_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FLIST     ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
